// File: include/n64adv_vparams.svh
`ifndef N64ADV_VPARAMS_SVH
`define N64ADV_VPARAMS_SVH

// Pixels per line
`define H_TOTAL_NTSC 773
`define H_TOTAL_PAL 794

// Lines per frame
`define V_TOTAL_NTSC 263
`define V_TOTAL_PAL 313

// Low widths of hsync in pixels and vsync in lines
`define HSYNC_LEN 57
`define VSYNC_LEN 3

// Back porch clamp window in pixels
`define CLAMP_START 70
`define CLAMP_LEN 30

// Pattern window, lines then pixels
`define PAT_VSTART_NTSC 18
`define PAT_VSTOP_NTSC 248
`define PAT_VSTART_PAL 22
`define PAT_VSTOP_PAL 296
`define PAT_HSTART_NTSC 120
`define PAT_HSTOP_NTSC 760
`define PAT_HSTART_PAL 128
`define PAT_HSTOP_PAL 780

`endif

// File: n64adv_vout.f
+incdir+include
verilog/n64adv_pkg.sv
verilog/vcfg_if.sv
verilog/vcfg_regs.sv
verilog/vtiming_gen.sv
verilog/testpattern.sv
verilog/n64adv_vout.sv
tb/tb_n64adv_vout.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_n64adv_vout -f n64adv_vout.f \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vtb_n64adv_vout 2>&1 | tee sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"

// File: tb/tb_n64adv_vout.sv
`include "n64adv_vparams.svh"

module tb_n64adv_vout;

  localparam int cw = n64adv_pkg::color_width_o;
  localparam int co = 3*cw;

  logic            VCLK = 1'b0;
  logic            nRST = 1'b0;
  logic            cfg_we = 1'b0;
  logic [1:0]      cfg_wdata = 2'b00;
  logic [co-1:0]   game_color = '0;
  logic            nVDSYNC;
  logic [co+3:0]   vdata_out;

  // Model state, updated on the rising edge
  logic m_nvd, m_upd, m_rst_seen, m_fs, m_col_pat, hs_rise, vs_rise;
  logic m_sh_mode, m_sh_en, m_live_mode, m_live_en, m_pend;
  int   m_h, m_v, m_ph, m_pv, frame_cnt, line_now;
  logic [3:0]    m_gsync;
  logic [co-1:0] col;
  logic [co+3:0] m_exp;
  // Output raster measurement
  logic [3:0] out_prev, cur;
  logic       line_armed, frame_armed, line_mode, frame_mode;
  int         pix, lines, frames_done;
  // Stimulus state
  logic [31:0] seed = 32'd71;
  int          burst_line, burst_left, burst_frame;

  n64adv_vout #(.COLOR_W(cw)) u_dut (
    .VCLK(VCLK), .nRST(nRST), .cfg_we(cfg_we), .cfg_wdata(cfg_wdata),
    .game_color(game_color), .nVDSYNC(nVDSYNC), .vdata_out(vdata_out)
  );

  always #2 VCLK = ~VCLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int h_total(input logic pal);
    return pal ? `H_TOTAL_PAL : `H_TOTAL_NTSC;
  endfunction

  function automatic int v_total(input logic pal);
    return pal ? `V_TOTAL_PAL : `V_TOTAL_NTSC;
  endfunction

  // Last write of each burst, {pattern_en, vmode} for the following frame
  function automatic logic [1:0] cfg_for_frame(input int n);
    case (n)
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  always @(posedge VCLK) begin
    m_rst_seen = !nRST;
    m_upd = 1'b0;
    if (!nRST) begin
      m_nvd = 1'b1;
      {m_sh_mode, m_sh_en, m_live_mode, m_live_en, m_pend} = '0;
      {m_h, m_v, m_ph, m_pv} = '0;
      m_gsync = 4'hf;
      m_exp = '0;
      m_col_pat = 1'b0;
    end else begin
      m_upd = ~m_nvd;
      m_fs = m_upd && (m_h == 0) && (m_v == 0);
      if (m_upd) begin
        // Pattern stage sees generator sync one strobe old
        hs_rise = ~m_exp[co+1] & m_gsync[1];
        vs_rise = ~m_exp[co+3] & m_gsync[3];
        col = '0;
        if ((m_pv > (m_live_mode ? `PAT_VSTART_PAL : `PAT_VSTART_NTSC)) &&
            (m_pv < (m_live_mode ? `PAT_VSTOP_PAL : `PAT_VSTOP_NTSC))) begin
          if (m_ph == (m_live_mode ? `PAT_HSTART_PAL : `PAT_HSTART_NTSC)) begin
            col = {co{m_pv[0]}};
          end else if ((m_ph > (m_live_mode ? `PAT_HSTART_PAL : `PAT_HSTART_NTSC)) &&
                       (m_ph < (m_live_mode ? `PAT_HSTOP_PAL : `PAT_HSTOP_NTSC))) begin
            col = {co{~m_exp[0]}};
          end
        end
        m_col_pat = m_live_en;
        if (!m_live_en) col = game_color;
        // Counters saturate, vsync edge wins the line count
        if (hs_rise) begin
          m_ph = 0;
          m_pv = (m_pv == 511) ? m_pv : m_pv + 1;
        end else begin
          m_ph = (m_ph == 1023) ? m_ph : m_ph + 1;
        end
        if (vs_rise) m_pv = 0;
        m_exp = {m_gsync, col};
        // Generator sync for the current raster position
        m_gsync[1] = m_h >= `HSYNC_LEN;
        m_gsync[3] = m_v >= `VSYNC_LEN;
        m_gsync[2] = !((m_h >= `CLAMP_START) && (m_h < `CLAMP_START + `CLAMP_LEN));
        m_gsync[0] = m_gsync[1] & m_gsync[3];
        if (m_h == h_total(m_live_mode) - 1) begin
          m_h = 0;
          m_v = (m_v == v_total(m_live_mode) - 1) ? 0 : m_v + 1;
        end else begin
          m_h = m_h + 1;
        end
      end
      // Live copy takes the shadow as it stood before this edge
      if (m_fs) {m_live_mode, m_live_en} = {m_sh_mode, m_sh_en};
      if (cfg_we) begin
        m_pend = 1'b1;
        {m_sh_en, m_sh_mode} = cfg_wdata;
      end else if (m_fs) begin
        m_pend = 1'b0;
      end
      m_nvd = ~m_nvd;
    end
    line_now  <= m_v;
    frame_cnt <= m_rst_seen ? 0 : frame_cnt + (m_fs ? 1 : 0);
  end

  ////////////////////
  // Stimulus
  ////////////////////

  always @(posedge VCLK) begin
    seed = lcg_next(seed);
    if (!nRST) begin
      burst_line = 20 + int'(seed % 32'd200);
      {burst_left, burst_frame} = '0;
    end else begin
      game_color <= seed[31:8];
      cfg_we <= 1'b0;
      if (burst_left != 0) begin
        // Junk writes first, only the last one should survive
        cfg_we <= 1'b1;
        cfg_wdata <= (burst_left == 1) ? cfg_for_frame(burst_frame) : seed[5:4];
        burst_left = burst_left - 1;
      end else if (frame_cnt >= 1 && frame_cnt <= 3 && burst_frame != frame_cnt &&
                   line_now == burst_line) begin
        burst_left  = 3;
        burst_frame = frame_cnt;
        burst_line  = 20 + int'(seed % 32'd200);
      end
    end
  end

  ////////////////////
  // Checks on the falling edge
  ////////////////////

  always @(negedge VCLK) begin
    if (m_rst_seen) begin
      check_value("reset", 32'(1), 32'(nVDSYNC));
      check_value("reset", 32'(0), 32'(vdata_out));
      {out_prev, line_armed, frame_armed} = '0;
      {pix, lines, frames_done} = '0;
    end else begin
      check_value("strobe", 32'(m_nvd), 32'(nVDSYNC));
      check_value("frame_config", 32'({m_live_mode, m_live_en, m_pend}),
                  32'({u_dut.cfg_bus.vmode, u_dut.cfg_bus.pattern_en,
                       u_dut.cfg_bus.cfg_pending}));
      check_value("sync_raster", 32'(m_exp[co+3:co]), 32'(vdata_out[co+3:co]));
      check_value(m_col_pat ? "checkerboard" : "pass_through", 32'(m_exp[co-1:0]),
                  32'(vdata_out[co-1:0]));
      if (m_upd) begin
        // Raster measured from the output sync alone
        cur = vdata_out[co+3:co];
        check_value("csync", 32'(cur[3] & cur[1]), 32'(cur[0]));
        pix = pix + 1;
        if (out_prev[1] && !cur[1]) begin
          if (line_armed) check_value("line_length", 32'(h_total(line_mode)), 32'(pix));
          {line_armed, line_mode} = {1'b1, m_live_mode};
          pix = 0;
          lines = lines + 1;
        end
        if (line_armed && !out_prev[1] && cur[1])
          check_value("hsync_width", 32'(`HSYNC_LEN), 32'(pix));
        if (line_armed && out_prev[2] && !cur[2])
          check_value("clamp_start", 32'(`CLAMP_START), 32'(pix));
        if (line_armed && !out_prev[2] && cur[2])
          check_value("clamp_end", 32'(`CLAMP_START + `CLAMP_LEN), 32'(pix));
        if (out_prev[3] && !cur[3]) begin
          if (frame_armed) begin
            check_value("frame_length", 32'(v_total(frame_mode)), 32'(lines));
            frames_done = frames_done + 1;
          end
          {frame_armed, frame_mode} = {1'b1, m_live_mode};
          lines = 0;
        end
        if (frame_armed && !out_prev[3] && cur[3])
          check_value("vsync_width", 32'(`VSYNC_LEN), 32'(lines));
        out_prev = cur;
      end
    end
  end

  // Four PAL frames of cycles plus a margin
  initial begin
    repeat (4 * `H_TOTAL_PAL * `V_TOTAL_PAL * 2 + 10000) @(posedge VCLK);
    $display("Timeout before the last frame was finished");
    $display("Errors found");
    $fatal(1, "watchdog");
  end

  initial begin
    repeat (4) @(posedge VCLK);
    nRST <= 1'b1;
    // NTSC pass, NTSC pattern, PAL pattern, PAL pass
    wait (frame_cnt == 5);
    repeat (40) @(posedge VCLK);
    assert (frames_done >= 4) else begin
      $display("Too few complete frames were seen on the output");
      $display("Errors found");
      $fatal(1, "frame count");
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: verilog/n64adv_pkg.sv
package n64adv_pkg;

  ////////////////////
  // Colour
  ////////////////////

  // Default bits per colour channel
  localparam int color_width_o = 8;

  ////////////////////
  // Sync and raster
  ////////////////////

  // Active low sync levels
  // [3] nVSYNC, [2] nCLAMP, [1] nHSYNC, [0] nCSYNC
  typedef logic [3:0] sync_t;

  // Pixel position within a line, covers up to 1023
  typedef logic [9:0] hcnt_t;

  // Line position within a frame, covers up to 511
  typedef logic [8:0] vcnt_t;

  // Video mode
  // 0 selects NTSC, 1 selects PAL
  typedef logic vmode_t;

endpackage

// File: verilog/n64adv_vout.sv
module n64adv_vout #(
  parameter int COLOR_W = n64adv_pkg::color_width_o
) (
  input  logic                 VCLK,
  input  logic                 nRST,
  input  logic                 cfg_we,
  input  logic [1:0]           cfg_wdata,
  input  logic [3*COLOR_W-1:0] game_color,
  output logic                 nVDSYNC,
  output logic [3*COLOR_W+3:0] vdata_out
);

  // Sync from the generator into the pattern stage
  n64adv_pkg::sync_t gen_sync;

  // Mode, enable and frame start shared by all three blocks
  vcfg_if cfg_bus ();

  ////////////////////
  // Blocks
  ////////////////////

  vcfg_regs u_vcfg_regs (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg_bus.regs)
  );

  vtiming_gen u_vtiming_gen (
    .VCLK    (VCLK),
    .nRST    (nRST),
    .nVDSYNC (nVDSYNC),
    .sync    (gen_sync),
    .cfg     (cfg_bus.timing)
  );

  testpattern #(
    .COLOR_W (COLOR_W)
  ) u_testpattern (
    .VCLK       (VCLK),
    .nRST       (nRST),
    .nVDSYNC    (nVDSYNC),
    .sync_in    (gen_sync),
    .game_color (game_color),
    .cfg        (cfg_bus.user),
    .vdata_out  (vdata_out)
  );

endmodule

// File: verilog/testpattern.sv
`include "n64adv_vparams.svh"

module testpattern #(
  parameter int COLOR_W = n64adv_pkg::color_width_o
) (
  input  logic                 VCLK,
  input  logic                 nRST,
  input  logic                 nVDSYNC,
  input  n64adv_pkg::sync_t    sync_in,
  input  logic [3*COLOR_W-1:0] game_color,
  vcfg_if.user                 cfg,
  output logic [3*COLOR_W+3:0] vdata_out
);

  // Colour part of the output word
  localparam int co_w = 3*COLOR_W;

  n64adv_pkg::hcnt_t hcnt;
  n64adv_pkg::vcnt_t vcnt;
  n64adv_pkg::hcnt_t pat_hstart;
  n64adv_pkg::hcnt_t pat_hstop;
  n64adv_pkg::vcnt_t pat_vstart;
  n64adv_pkg::vcnt_t pat_vstop;
  logic              strobe;
  logic              posedge_nhsync;
  logic              posedge_nvsync;
  logic              in_vwin;
  logic [co_w-1:0]   pat_color;

  assign strobe = ~nVDSYNC;

  ////////////////////
  // Sync edges
  ////////////////////

  // Previous sync sits in the top four bits of the output
  assign posedge_nvsync = ~vdata_out[co_w+3] & sync_in[3];
  assign posedge_nhsync = ~vdata_out[co_w+1] & sync_in[1];

  ////////////////////
  // Pattern window
  ////////////////////

  assign pat_vstart = cfg.vmode ? n64adv_pkg::vcnt_t'(`PAT_VSTART_PAL)
                                : n64adv_pkg::vcnt_t'(`PAT_VSTART_NTSC);
  assign pat_vstop  = cfg.vmode ? n64adv_pkg::vcnt_t'(`PAT_VSTOP_PAL)
                                : n64adv_pkg::vcnt_t'(`PAT_VSTOP_NTSC);
  assign pat_hstart = cfg.vmode ? n64adv_pkg::hcnt_t'(`PAT_HSTART_PAL)
                                : n64adv_pkg::hcnt_t'(`PAT_HSTART_NTSC);
  assign pat_hstop  = cfg.vmode ? n64adv_pkg::hcnt_t'(`PAT_HSTOP_PAL)
                                : n64adv_pkg::hcnt_t'(`PAT_HSTOP_NTSC);

  // Limits are exclusive on both sides vertically
  assign in_vwin = (vcnt > pat_vstart) && (vcnt < pat_vstop);

  // Checkerboard colour
  always_comb begin
    pat_color = '0;
    if (in_vwin) begin
      if (hcnt == pat_hstart) begin
        // Line parity seeds the first pixel
        pat_color = {co_w{vcnt[0]}};
      end else if ((hcnt > pat_hstart) && (hcnt < pat_hstop)) begin
        // Flip against the last pixel sent
        pat_color = {co_w{~vdata_out[0]}};
      end
    end
  end

  ////////////////////
  // Counters and output
  ////////////////////

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      hcnt      <= '0;
      vcnt      <= '0;
      vdata_out <= '0;
    end else if (strobe) begin
      // Both counters saturate at all ones
      if (posedge_nhsync) begin
        hcnt <= '0;
        vcnt <= (&vcnt) ? vcnt : vcnt + 1'b1;
      end else begin
        hcnt <= (&hcnt) ? hcnt : hcnt + 1'b1;
      end
      // Vsync edge takes priority on the line count
      if (posedge_nvsync) begin
        vcnt <= '0;
      end
      vdata_out[co_w+3:co_w] <= sync_in;
      // Pass game colour through when the pattern is off
      vdata_out[co_w-1:0] <= cfg.pattern_en ? pat_color : game_color;
    end
  end

endmodule

// File: verilog/vcfg_if.sv
interface vcfg_if;

  // Live configuration, frame aligned
  n64adv_pkg::vmode_t vmode;
  logic               pattern_en;

  // Shadow holds a write not yet applied
  logic               cfg_pending;

  // First strobe of line 0, pixel 0
  logic               frame_start;

  // Register block owns the live copy
  modport regs (output vmode, output pattern_en, output cfg_pending, input frame_start);

  // Timing generator picks raster size and marks frame start
  modport timing (input vmode, output frame_start);

  // Pattern block only reads the settings
  modport user (input vmode, input pattern_en);

endinterface

// File: verilog/vcfg_regs.sv
module vcfg_regs (
  input  logic       VCLK,
  input  logic       nRST,
  input  logic       cfg_we,
  input  logic [1:0] cfg_wdata,
  vcfg_if.regs       cfg
);

  ////////////////////
  // Shadow copy
  ////////////////////

  n64adv_pkg::vmode_t shadow_vmode;
  logic               shadow_pattern_en;

  // Writes land here first
  // A burst in one frame keeps only the last value
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      shadow_vmode      <= 1'b0;
      shadow_pattern_en <= 1'b0;
    end else if (cfg_we) begin
      shadow_vmode      <= cfg_wdata[0];
      shadow_pattern_en <= cfg_wdata[1];
    end
  end

  ////////////////////
  // Live copy
  ////////////////////

  // Taken over only at frame start, so one frame never mixes two modes
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      cfg.vmode      <= 1'b0;
      cfg.pattern_en <= 1'b0;
    end else if (cfg.frame_start) begin
      cfg.vmode      <= shadow_vmode;
      cfg.pattern_en <= shadow_pattern_en;
    end
  end

  // Pending flag
  // A write in the frame start cycle stays pending for the next frame
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      cfg.cfg_pending <= 1'b0;
    end else if (cfg_we) begin
      cfg.cfg_pending <= 1'b1;
    end else if (cfg.frame_start) begin
      cfg.cfg_pending <= 1'b0;
    end
  end

endmodule

// File: verilog/vtiming_gen.sv
`include "n64adv_vparams.svh"

module vtiming_gen (
  input  logic              VCLK,
  input  logic              nRST,
  output logic              nVDSYNC,
  output n64adv_pkg::sync_t sync,
  vcfg_if.timing            cfg
);

  // Raster constants at counter width
  localparam n64adv_pkg::hcnt_t h_last_ntsc = n64adv_pkg::hcnt_t'(`H_TOTAL_NTSC - 1);
  localparam n64adv_pkg::hcnt_t h_last_pal  = n64adv_pkg::hcnt_t'(`H_TOTAL_PAL - 1);
  localparam n64adv_pkg::vcnt_t v_last_ntsc = n64adv_pkg::vcnt_t'(`V_TOTAL_NTSC - 1);
  localparam n64adv_pkg::vcnt_t v_last_pal  = n64adv_pkg::vcnt_t'(`V_TOTAL_PAL - 1);
  localparam n64adv_pkg::hcnt_t hsync_len   = n64adv_pkg::hcnt_t'(`HSYNC_LEN);
  localparam n64adv_pkg::vcnt_t vsync_len   = n64adv_pkg::vcnt_t'(`VSYNC_LEN);
  localparam n64adv_pkg::hcnt_t clamp_start = n64adv_pkg::hcnt_t'(`CLAMP_START);
  localparam n64adv_pkg::hcnt_t clamp_stop  = n64adv_pkg::hcnt_t'(`CLAMP_START + `CLAMP_LEN);

  n64adv_pkg::hcnt_t hcnt;
  n64adv_pkg::vcnt_t vcnt;
  n64adv_pkg::hcnt_t h_last;
  n64adv_pkg::vcnt_t v_last;
  logic              strobe;
  logic              hsync_act;
  logic              vsync_act;
  logic              clamp_act;

  ////////////////////
  // Pixel strobe
  ////////////////////

  // Toggles every cycle, high right after reset
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      nVDSYNC <= 1'b1;
    end else begin
      nVDSYNC <= ~nVDSYNC;
    end
  end

  // Low phase qualifies a pixel
  assign strobe = ~nVDSYNC;

  ////////////////////
  // Raster counters
  ////////////////////

  // Line and frame lengths follow the live mode
  assign h_last = cfg.vmode ? h_last_pal : h_last_ntsc;
  assign v_last = cfg.vmode ? v_last_pal : v_last_ntsc;

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (strobe) begin
      if (hcnt >= h_last) begin
        hcnt <= '0;
        // End of line, step or wrap the line counter
        if (vcnt >= v_last) begin
          vcnt <= '0;
        end else begin
          vcnt <= vcnt + 1'b1;
        end
      end else begin
        hcnt <= hcnt + 1'b1;
      end
    end
  end

  // Frame start marks pixel 0 of line 0, strobe qualified
  assign cfg.frame_start = strobe && (hcnt == '0) && (vcnt == '0);

  ////////////////////
  // Sync levels
  ////////////////////

  // Active windows for the current pixel
  assign hsync_act = hcnt < hsync_len;
  assign vsync_act = vcnt < vsync_len;
  assign clamp_act = (hcnt >= clamp_start) && (hcnt < clamp_stop);

  // Registered on the strobe, idle high out of reset
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      sync <= '1;
    end else if (strobe) begin
      sync[3] <= ~vsync_act;
      sync[2] <= ~clamp_act;
      sync[1] <= ~hsync_act;
      // Composite is low whenever either sync is low
      sync[0] <= ~(hsync_act | vsync_act);
    end
  end

endmodule
